// ==== bench/dcache_assert.sv ====
/*
 * handshake properties of the cache controller, bound into every dcache_ctrl
 * memory acknowledges are assumed to close exactly one outstanding request
 */
`timescale 1ns/1ps

module dcache_assert (
    input logic clk,
    input logic rst_n_i,
    input logic ready_i,
    input logic done_i,
    input logic mem_req_valid_i,
    input logic mem_ack_i
);

    logic outstanding_q;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            outstanding_q <= 1'b0;
        end else if (mem_req_valid_i) begin
            outstanding_q <= 1'b1;
        end else if (mem_ack_i) begin
            outstanding_q <= 1'b0;
        end
    end

    done_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        done_i |=> !done_i)
        else $error("done_o held high for more than one cycle");

    mem_req_single: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_req_valid_i |=> !mem_req_valid_i)
        else $error("mem_req_valid_o held high for more than one cycle");

    ready_done_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(ready_i && done_i))
        else $error("ready_o and done_o high together");

    no_req_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
        ready_i |-> !mem_req_valid_i)
        else $error("memory request issued while idle");

    // one memory request in flight at most
    one_outstanding: assert property (@(posedge clk) disable iff (!rst_n_i)
        mem_req_valid_i |-> !outstanding_q)
        else $error("memory request issued before previous acknowledge");

endmodule

bind dcache_ctrl dcache_assert u_assert (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .ready_i         (ready_o),
    .done_i          (done_o),
    .mem_req_valid_i (mem_req_valid_o),
    .mem_ack_i       (mem_ack_i)
);

// ==== bench/dcache_tb.sv ====
/*
 * random and directed traffic against a shadow model of the 2-way cache
 * backing memory acks 1 to 4 cycles after each request
 */
`timescale 1ns/1ps

module dcache_tb
    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;
();

    localparam int TIMEOUT = 200;

    logic              clk;
    logic              rst_n_i;
    logic              req_valid_i;
    cpu_req_t          req_i;
    logic              ready_o;
    logic              done_o;
    logic [WORD_W-1:0] rdata_o;
    logic              mem_req_valid_o;
    mem_req_t          mem_req_o;
    logic              mem_ack_i;
    logic [WORD_W-1:0] mem_rdata_i;

    integer            seed = 32'h2b27aacf;
    int                errors = 0;
    int                err_mark = 0;
    int                tests_run = 0;
    int                tests_failed = 0;
    string             cur_test = "init";

    logic [WORD_W-1:0] shadow [logic [ADDR_W-1:0]];
    logic [WORD_W-1:0] backing [logic [ADDR_W-1:0]];
    logic [ADDR_W:0]   req_log [$];
    tag_entry_t        m_ent [NUM_SETS][NUM_WAYS];
    way_t              m_lru [NUM_SETS];

    tag_t   tag_pool [4] = '{23'h000001, 23'h0002a5, 23'h07fff0, 23'h00003c};
    index_t set_pool [4] = '{6'd3, 6'd17, 6'd40, 6'd63};

    dcache_top uut (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .req_valid_i     (req_valid_i),
        .req_i           (req_i),
        .ready_o         (ready_o),
        .done_o          (done_o),
        .rdata_o         (rdata_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_o       (mem_req_o),
        .mem_ack_i       (mem_ack_i),
        .mem_rdata_i     (mem_rdata_i)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [WORD_W-1:0] init_word(input logic [ADDR_W-1:0] a);
        return {a ^ 32'h5a5a0f0f, ~a};
    endfunction

    function automatic logic [WORD_W-1:0] visible(input logic [ADDR_W-1:0] a);
        return shadow.exists(a) ? shadow[a] : init_word(a);
    endfunction

    function automatic logic [WORD_W-1:0] merge(input logic [WORD_W-1:0] old,
                                                input logic [WORD_W-1:0] data,
                                                input logic [STRB_W-1:0] strb);
        logic [WORD_W-1:0] res;
        for (int b = 0; b < STRB_W; b++) begin
            res[b*8 +: 8] = strb[b] ? data[b*8 +: 8] : old[b*8 +: 8];
        end
        return res;
    endfunction

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout in %s: %s did not rise in %0d cycles", cur_test, what, TIMEOUT);
        $display("TEST FAIL");
        $finish;
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_mark = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
        end
        $display("%-12s %s", cur_test, (errors == err_mark) ? "passed" : "failed");
    endtask

    // backing memory stores writebacks and answers fills
    initial begin : responder
        int                delay;
        logic [ADDR_W-1:0] a;
        mem_ack_i   = 1'b0;
        mem_rdata_i = '0;
        forever begin
            @(negedge clk);
            mem_ack_i = 1'b0;
            if (mem_req_valid_o) begin
                a = mem_req_o.addr;
                req_log.push_back({mem_req_o.write, a});
                if (mem_req_o.write) begin
                    check({cur_test, " writeback"}, visible(a), mem_req_o.data);
                    backing[a] = mem_req_o.data;
                end
                delay = 1 + ($unsigned($random(seed)) % 4);
                repeat (delay) @(negedge clk);
                mem_rdata_i = backing.exists(a) ? backing[a] : init_word(a);
                mem_ack_i   = 1'b1;
            end
        end
    end

    // one request through the DUT, predicted and checked against the model
    task automatic access(input logic wr, input logic [ADDR_W-1:0] addr,
                          input logic [WORD_W-1:0] wdata, input logic [STRB_W-1:0] strb);
        logic [ADDR_W-1:0] line;
        index_t            idx;
        tag_t              tag;
        logic              hit;
        way_t              way;
        logic [ADDR_W:0]   exp_log [$];
        logic [WORD_W-1:0] exp_data;
        int                n;
        line     = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        idx      = addr[OFFSET_W +: INDEX_W];
        tag      = addr[ADDR_W-1 -: TAG_W];
        exp_data = visible(line);
        hit      = 1'b0;
        way      = 1'b0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_ent[idx][w].valid && (m_ent[idx][w].tag == tag)) begin
                hit = 1'b1;
                way = way_t'(w);
            end
        end
        if (!hit) begin
            // invalid way first, then the recency bit
            way = !m_ent[idx][0].valid ? 1'b0 : (!m_ent[idx][1].valid ? 1'b1 : m_lru[idx]);
            if (m_ent[idx][way].valid && m_ent[idx][way].dirty) begin
                exp_log.push_back({1'b1, m_ent[idx][way].tag, idx, {OFFSET_W{1'b0}}});
            end
            exp_log.push_back({1'b0, line});
            m_ent[idx][way] = '{valid: 1'b1, dirty: 1'b0, tag: tag};
        end
        if (wr) begin
            m_ent[idx][way].dirty = 1'b1;
        end
        m_lru[idx] = ~way;

        n = 0;
        while (!ready_o && (n < TIMEOUT)) begin
            @(negedge clk);
            n++;
        end
        if (!ready_o) begin
            abort_on_timeout("ready_o");
        end
        req_log.delete();
        req_i       = '{write: wr, addr: addr, wdata: wdata, strb: strb};
        req_valid_i = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            req_valid_i = 1'b0;
            n++;
        end while (!done_o && (n < TIMEOUT));
        if (!done_o) begin
            abort_on_timeout("done_o");
        end

        if (wr) begin
            shadow[line] = merge(exp_data, wdata, strb);
        end else begin
            check(cur_test, exp_data, rdata_o);
        end
        if (hit) begin
            check({cur_test, " hit latency"}, 1, n);
        end
        check({cur_test, " mem requests"}, exp_log.size(), req_log.size());
        foreach (exp_log[i]) begin
            if (i < req_log.size()) begin
                check({cur_test, " mem request"}, exp_log[i], req_log[i]);
            end
        end
    endtask

    initial begin : stimulus
        logic [31:0]       r;
        logic [ADDR_W-1:0] addr;
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        for (int s = 0; s < NUM_SETS; s++) begin
            m_lru[s] = 1'b0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                m_ent[s][w] = '0;
            end
        end

        begin_test("reset");
        for (int c = 0; c < 11; c++) begin
            @(negedge clk);
            check(cur_test, 1, ready_o);
            check(cur_test, 0, done_o);
            check(cur_test, 0, mem_req_valid_o);
            // release after the tenth low cycle
            if (c == 9) begin
                rst_n_i = 1'b1;
            end
        end
        end_test();

        begin_test("read_hit");
        access(1'b0, 32'h00000a55, '0, '0);
        access(1'b0, 32'h00000a55, '0, '0);
        end_test();

        begin_test("write_merge");
        access(1'b1, 32'h00000a55, {$random(seed), $random(seed)}, STRB_W'($random(seed)));
        access(1'b0, 32'h00000a50, '0, '0);
        end_test();

        // set 20 is untouched so far and both ways fill dirty before the third tag
        begin_test("dirty_evict");
        access(1'b1, {23'h000100, 6'd20, 3'd0}, {$random(seed), $random(seed)}, 8'hff);
        access(1'b1, {23'h000200, 6'd20, 3'd0}, {$random(seed), $random(seed)}, 8'h3c);
        access(1'b0, {23'h000300, 6'd20, 3'd0}, '0, '0);
        access(1'b0, {23'h000100, 6'd20, 3'd0}, '0, '0);
        access(1'b0, {23'h000200, 6'd20, 3'd0}, '0, '0);
        end_test();

        begin_test("random_mix");
        repeat (400) begin
            r    = $random(seed);
            addr = {tag_pool[r[1:0]], set_pool[r[3:2]], r[6:4]};
            access(r[7], addr, {$random(seed), $random(seed)}, STRB_W'($random(seed)));
        end
        end_test();

        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
src/dcache_geom_pkg.sv
src/dcache_bus_pkg.sv
src/dcache_array.sv
src/dcache_way.sv
src/dcache_way_select.sv
src/dcache_ctrl.sv
src/dcache_top.sv
bench/dcache_assert.sv
bench/dcache_tb.sv

// ==== src/dcache_array.sv ====
/*
 * set-indexed storage, combinational read and clocked write
 * every entry is cleared by reset
 */
`timescale 1ns/1ps

module dcache_array
    import dcache_geom_pkg::*;
#(
    parameter type entry_t = logic [WORD_W-1:0],
    parameter int  DEPTH   = NUM_SETS
) (
    input  logic   clk,
    input  logic   rst_n_i,
    input  index_t rd_idx_i,
    output entry_t rd_o,
    input  logic   we_i,
    input  index_t wr_idx_i,
    input  entry_t wr_i
);

    entry_t mem_q [DEPTH];

    assign rd_o = mem_q[rd_idx_i];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end else if (we_i) begin
            mem_q[wr_idx_i] <= wr_i;
        end
    end

endmodule

// ==== src/dcache_bus_pkg.sv ====
/*
 * transaction structs for the processor side, the memory side and the
 * per-way write and read paths; memory data is used only by writebacks
 */
package dcache_bus_pkg;

    import dcache_geom_pkg::*;

    // processor request, strb only matters on a write
    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
        logic [STRB_W-1:0] strb;
    } cpu_req_t;

    // memory request, addr is word aligned
    typedef struct packed {
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] data;
    } mem_req_t;

    // write command into one way
    typedef struct packed {
        logic              tag_we;
        tag_entry_t        tag;
        logic [STRB_W-1:0] be;
        logic [WORD_W-1:0] data;
    } way_wr_t;

    // contents of one way at the current index
    typedef struct packed {
        tag_entry_t        tag;
        logic [WORD_W-1:0] data;
    } way_rd_t;

endpackage

// ==== src/dcache_ctrl.sv ====
/*
 * single-request controller: lookup, optional writeback, then fill
 * a miss fills the line and looks up again, so writes always merge as hits
 * memory must acknowledge no earlier than one cycle after each request
 */
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              req_valid_i,
    input  cpu_req_t          req_i,
    output logic              ready_o,
    output logic              done_o,
    output logic [WORD_W-1:0] rdata_o,
    output index_t            idx_o,
    output tag_t              tag_o,
    output way_t              lru_o,
    input  logic              hit_i,
    input  way_t              hit_way_i,
    input  logic [WORD_W-1:0] hit_data_i,
    input  way_t              victim_way_i,
    input  way_rd_t           victim_i,
    output way_wr_t           way_wr_o [NUM_WAYS],
    output logic              mem_req_valid_o,
    output mem_req_t          mem_req_o,
    input  logic              mem_ack_i,
    input  logic [WORD_W-1:0] mem_rdata_i
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WB,
        S_FILL_REQ,
        S_FILL_WAIT
    } state_t;

    state_t   state_q;
    state_t   state_d;
    cpu_req_t req_q;
    logic     wb_sent_q;
    way_t     lru_q [NUM_SETS];

    assign ready_o = (state_q == S_IDLE);
    assign done_o  = (state_q == S_LOOKUP) && hit_i;
    assign rdata_o = hit_data_i;

    assign idx_o = req_q.addr[OFFSET_W +: INDEX_W];
    assign tag_o = req_q.addr[ADDR_W-1 -: TAG_W];
    assign lru_o = lru_q[idx_o];

    always_ff @(posedge clk) begin
        if (req_valid_i && ready_o) begin
            req_q <= req_i;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (req_valid_i) begin
                    state_d = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (hit_i) begin
                    state_d = S_IDLE;
                end else if (victim_i.tag.valid && victim_i.tag.dirty) begin
                    state_d = S_WB;
                end else begin
                    state_d = S_FILL_REQ;
                end
            end
            S_WB: begin
                if (mem_ack_i) begin
                    state_d = S_FILL_REQ;
                end
            end
            S_FILL_REQ: state_d = S_FILL_WAIT;
            S_FILL_WAIT: begin
                if (mem_ack_i) begin
                    state_d = S_LOOKUP;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= S_IDLE;
            wb_sent_q <= 1'b0;
            for (int s = 0; s < NUM_SETS; s++) begin
                lru_q[s] <= 1'b0;
            end
        end else begin
            state_q <= state_d;
            if (mem_ack_i) begin
                wb_sent_q <= 1'b0;
            end else if (state_q == S_WB) begin
                wb_sent_q <= 1'b1;
            end
            // point recency at the way not just used
            if (done_o) begin
                lru_q[idx_o] <= ~hit_way_i;
            end
        end
    end

    // writeback strobes only on the first WB cycle
    assign mem_req_valid_o = (state_q == S_FILL_REQ) || ((state_q == S_WB) && !wb_sent_q);

    always_comb begin
        mem_req_o.write = (state_q == S_WB);
        mem_req_o.data  = victim_i.data;
        if (state_q == S_WB) begin
            mem_req_o.addr = {victim_i.tag.tag, idx_o, {OFFSET_W{1'b0}}};
        end else begin
            mem_req_o.addr = {tag_o, idx_o, {OFFSET_W{1'b0}}};
        end
    end

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_wr_o[w] = '0;
        end
        if ((state_q == S_LOOKUP) && hit_i && req_q.write) begin
            way_wr_o[hit_way_i].tag_we    = 1'b1;
            way_wr_o[hit_way_i].tag.valid = 1'b1;
            way_wr_o[hit_way_i].tag.dirty = 1'b1;
            way_wr_o[hit_way_i].tag.tag   = tag_o;
            way_wr_o[hit_way_i].be        = req_q.strb;
            way_wr_o[hit_way_i].data      = req_q.wdata;
        end else if ((state_q == S_FILL_WAIT) && mem_ack_i) begin
            // clean line, whole word from memory
            way_wr_o[victim_way_i].tag_we    = 1'b1;
            way_wr_o[victim_way_i].tag.valid = 1'b1;
            way_wr_o[victim_way_i].tag.dirty = 1'b0;
            way_wr_o[victim_way_i].tag.tag   = tag_o;
            way_wr_o[victim_way_i].be        = '1;
            way_wr_o[victim_way_i].data      = mem_rdata_i;
        end
    end

endmodule

// ==== src/dcache_geom_pkg.sv ====
/*
 * geometry of the 2-way data cache: 64 sets of one 64-bit word per line
 * addresses are 32 bits and split as tag | index | byte offset
 */
package dcache_geom_pkg;

    localparam int ADDR_W   = 32;
    localparam int WORD_W   = 64;
    localparam int STRB_W   = WORD_W / 8;
    localparam int OFFSET_W = 3;
    localparam int INDEX_W  = 6;
    localparam int NUM_SETS = 1 << INDEX_W;
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;
    localparam int NUM_WAYS = 2;

    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;

    // way number, one bit is enough for two ways
    typedef logic way_t;

    // 25-bit entry held per set and way
    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

endpackage

// ==== src/dcache_top.sv ====
/*
 * 2-way write-back data cache, one request in flight at a time
 * done_o ends every request; rdata_o is valid with done_o on reads
 */
`timescale 1ns/1ps

module dcache_top
    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              req_valid_i,
    input  cpu_req_t          req_i,
    output logic              ready_o,
    output logic              done_o,
    output logic [WORD_W-1:0] rdata_o,
    output logic              mem_req_valid_o,
    output mem_req_t          mem_req_o,
    input  logic              mem_ack_i,
    input  logic [WORD_W-1:0] mem_rdata_i
);

    index_t            idx;
    tag_t              tag;
    way_t              lru;
    logic              hit;
    way_t              hit_way;
    logic [WORD_W-1:0] hit_data;
    way_t              victim_way;
    way_rd_t           victim;
    way_wr_t           way_wr [NUM_WAYS];
    way_rd_t           way_rd [NUM_WAYS];

    dcache_ctrl u_ctrl (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .req_valid_i     (req_valid_i),
        .req_i           (req_i),
        .ready_o         (ready_o),
        .done_o          (done_o),
        .rdata_o         (rdata_o),
        .idx_o           (idx),
        .tag_o           (tag),
        .lru_o           (lru),
        .hit_i           (hit),
        .hit_way_i       (hit_way),
        .hit_data_i      (hit_data),
        .victim_way_i    (victim_way),
        .victim_i        (victim),
        .way_wr_o        (way_wr),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_o       (mem_req_o),
        .mem_ack_i       (mem_ack_i),
        .mem_rdata_i     (mem_rdata_i)
    );

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        dcache_way u_way (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .idx_i   (idx),
            .wr_i    (way_wr[w]),
            .rd_o    (way_rd[w])
        );
    end

    dcache_way_select u_select (
        .ways_i       (way_rd),
        .tag_i        (tag),
        .lru_i        (lru),
        .hit_o        (hit),
        .hit_way_o    (hit_way),
        .hit_data_o   (hit_data),
        .victim_way_o (victim_way),
        .victim_o     (victim)
    );

endmodule

// ==== src/dcache_way.sv ====
/*
 * one cache way: tag array plus data array at a shared index
 * byte enables merge into the stored word, a full fill sets all of them
 */
`timescale 1ns/1ps

module dcache_way
    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  index_t  idx_i,
    input  way_wr_t wr_i,
    output way_rd_t rd_o
);

    tag_entry_t        tag_rd;
    logic [WORD_W-1:0] data_rd;
    logic [WORD_W-1:0] data_merged;
    logic              data_we;

    dcache_array #(
        .entry_t (tag_entry_t),
        .DEPTH   (NUM_SETS)
    ) u_tag_array (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .rd_idx_i (idx_i),
        .rd_o     (tag_rd),
        .we_i     (wr_i.tag_we),
        .wr_idx_i (idx_i),
        .wr_i     (wr_i.tag)
    );

    // keep the bytes that are not enabled
    always_comb begin
        for (int b = 0; b < STRB_W; b++) begin
            data_merged[b*8 +: 8] = wr_i.be[b] ? wr_i.data[b*8 +: 8] : data_rd[b*8 +: 8];
        end
    end

    assign data_we = |wr_i.be;

    dcache_array #(
        .entry_t (logic [WORD_W-1:0]),
        .DEPTH   (NUM_SETS)
    ) u_data_array (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .rd_idx_i (idx_i),
        .rd_o     (data_rd),
        .we_i     (data_we),
        .wr_idx_i (idx_i),
        .wr_i     (data_merged)
    );

    assign rd_o.tag  = tag_rd;
    assign rd_o.data = data_rd;

endmodule

// ==== src/dcache_way_select.sv ====
/*
 * hit detection and victim choice over both ways, purely combinational
 * victim rule: way 0 if invalid, else way 1 if invalid, else the recency bit
 */
`timescale 1ns/1ps

module dcache_way_select
    import dcache_geom_pkg::*;
    import dcache_bus_pkg::*;
(
    input  way_rd_t           ways_i [NUM_WAYS],
    input  tag_t              tag_i,
    input  way_t              lru_i,
    output logic              hit_o,
    output way_t              hit_way_o,
    output logic [WORD_W-1:0] hit_data_o,
    output way_t              victim_way_o,
    output way_rd_t           victim_o
);

    // a tag lives in at most one way, so the last match wins harmlessly
    always_comb begin
        hit_o     = 1'b0;
        hit_way_o = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (ways_i[w].tag.valid && (ways_i[w].tag.tag == tag_i)) begin
                hit_o     = 1'b1;
                hit_way_o = way_t'(w);
            end
        end
    end

    assign hit_data_o = ways_i[hit_way_o].data;

    always_comb begin
        if (!ways_i[0].tag.valid) begin
            victim_way_o = 1'b0;
        end else if (!ways_i[1].tag.valid) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = lru_i;
        end
    end

    assign victim_o = ways_i[victim_way_o];

endmodule
